// ==== mgt_port_pkg.sv ====
// MGT port control plane definitions
// Protocol codes, register map, field widths and the packed
// structs shared by the status, register and activity stages

package mgt_port_pkg;

  // ------------------------------
  // Widths and constants
  // ------------------------------
  localparam int REG_AWIDTH     = 14;
  localparam int REG_DWIDTH     = 32;
  localparam logic [7:0] COMPAT_NUM = 8'd2;  // Bumped on map changes
  localparam int LOCK_LAT_WIDTH = 20;        // Top 16 bits reported

  // Register offsets, added to REG_BASE
  localparam logic [REG_AWIDTH-1:0] REG_PORT_INFO       = 14'h0;
  localparam logic [REG_AWIDTH-1:0] REG_MAC_CTRL_STATUS = 14'h4;
  localparam logic [REG_AWIDTH-1:0] REG_PHY_CTRL_STATUS = 14'h8;
  localparam logic [REG_AWIDTH-1:0] REG_MAC_LED_CTL     = 14'hC;

  // ------------------------------
  // Types
  // ------------------------------
  typedef enum logic [7:0] {
    DISABLED = 8'd0,
    GBE1     = 8'd1,
    GBE10    = 8'd2,
    AURORA   = 8'd3
  } mgt_protocol_e;

  // Register port request, single-cycle strobes
  typedef struct packed {
    logic                  wr_req;
    logic [REG_AWIDTH-1:0] wr_addr;
    logic [REG_DWIDTH-1:0] wr_data;
    logic                  rd_req;
    logic [REG_AWIDTH-1:0] rd_addr;
  } reg_req_t;

  typedef struct packed {
    logic                  rd_resp;
    logic [REG_DWIDTH-1:0] rd_data;
  } reg_resp_t;

  // Raw link flags from the PHY side, not in bus_clk
  typedef struct packed {
    logic crit_err;
    logic soft_err;
    logic hard_err;
    logic channel_up;  // Bit 0
  } link_flags_t;

  typedef struct packed {
    logic [20:0] rsvd_hi;     // Stored, no function
    logic        mac_clear;   // Bit 10
    logic        phy_areset;  // Bit 9
    logic [7:0]  rsvd_lo;     // Bits 8..1
    logic        checker_en;  // Bit 0
  } mac_ctrl_t;

  typedef struct packed {
    logic identify_val;  // Bit 1
    logic identify_en;   // Bit 0
  } led_ctl_t;

  typedef struct packed {
    logic [REG_DWIDTH-1:0] mac_status;  // Upper half
    logic [REG_DWIDTH-1:0] phy_status;
  } port_status_t;

endpackage

// ==== mgt_status_stage.sv ====
// MGT port status conditioning
// Brings the link flags into bus_clk, holds the critical error
// until cleared, times BIST lock and registers the status words

`timescale 1ns/100ps

module mgt_status_stage (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  mgt_port_pkg::link_flags_t link_flags_i,   // Async to bus_clk
  input  logic                      bist_locked_i,
  input  logic                      checker_en_i,
  input  logic                      mac_clear_i,
  output mgt_port_pkg::port_status_t status_o,
  output logic                      link_up_o
);

  import mgt_port_pkg::*;

  link_flags_t               flags_meta;   // First sync stage
  link_flags_t               flags_sync;   // Safe to use from here
  logic                      crit_latch;
  logic [LOCK_LAT_WIDTH-1:0] lock_lat;
  logic [REG_DWIDTH-1:0]     mac_status_d;
  logic [REG_DWIDTH-1:0]     phy_status_d;

  // ------------------------------
  // Flag synchronizer
  // ------------------------------
  // Two flop chain per flag
  always_ff @(posedge bus_clk) begin
    flags_meta <= link_flags_i;
    flags_sync <= flags_meta;
  end

  // ------------------------------
  // Critical error latch
  // ------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst || mac_clear_i) begin
      crit_latch <= 1'b0;
    end else if (flags_sync.crit_err) begin
      crit_latch <= 1'b1;  // Sticky until software clears
    end
  end

  // ------------------------------
  // BIST lock latency
  // ------------------------------
  // Counts cycles from checker enable until the checker locks
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_lat <= '0;
    end else if (!bist_locked_i) begin
      if (checker_en_i) begin
        lock_lat <= lock_lat + 1'b1;  // Waiting for lock
      end else begin
        lock_lat <= '0;               // Idle, rearm
      end
    end
    // Last value held for readback while locked
  end

  // Status word layout
  assign mac_status_d = {
    6'h0,                                // 31..26
    crit_latch,                          // 25
    1'b1,                                // 24, always set
    4'h0,                                // 23..20
    lock_lat[LOCK_LAT_WIDTH-1:4],        // 19..4, coarse latency
    bist_locked_i,                       // 3
    flags_sync.soft_err,                 // 2
    flags_sync.hard_err,                 // 1
    flags_sync.channel_up                // 0
  };

  assign phy_status_d = {
    30'h0,
    flags_sync.hard_err,
    flags_sync.channel_up
  };

  // Output register adds the third cycle of flag latency
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      status_o  <= '0;
      link_up_o <= 1'b0;
    end else begin
      status_o.mac_status <= mac_status_d;
      status_o.phy_status <= phy_status_d;
      link_up_o           <= flags_sync.channel_up;
    end
  end

endmodule

// ==== mgt_reg_stage.sv ====
// MGT port register block
// Control registers with protocol dependent reset values,
// port info word and a fixed two-edge read response

`timescale 1ns/100ps

module mgt_reg_stage #(
  parameter mgt_port_pkg::mgt_protocol_e PROTOCOL = mgt_port_pkg::GBE10,
  parameter int                          REG_BASE = 0,
  parameter logic [7:0]                  PORTNUM  = 8'd0
) (
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  input  mgt_port_pkg::reg_req_t     reg_req_i,
  input  mgt_port_pkg::port_status_t status_i,
  input  logic                       link_up_i,
  input  logic                       activity_i,
  output mgt_port_pkg::reg_resp_t    reg_resp_o,
  output mgt_port_pkg::mac_ctrl_t    mac_ctrl_o,
  output logic                       phy_areset_o,  // PHY ctrl bit 0
  output mgt_port_pkg::led_ctl_t     led_ctl_o,
  output logic [31:0]                port_info_o
);

  import mgt_port_pkg::*;

  // Absolute addresses
  localparam logic [REG_AWIDTH-1:0] ADDR_PORT_INFO = REG_AWIDTH'(REG_BASE + REG_PORT_INFO);
  localparam logic [REG_AWIDTH-1:0] ADDR_MAC_CS    = REG_AWIDTH'(REG_BASE + REG_MAC_CTRL_STATUS);
  localparam logic [REG_AWIDTH-1:0] ADDR_PHY_CS    = REG_AWIDTH'(REG_BASE + REG_PHY_CTRL_STATUS);
  localparam logic [REG_AWIDTH-1:0] ADDR_LED_CTL   = REG_AWIDTH'(REG_BASE + REG_MAC_LED_CTL);

  // Ethernet MACs come up with the checker/tx enable set
  localparam mac_ctrl_t MAC_CTRL_RST = ((PROTOCOL == GBE1) || (PROTOCOL == GBE10)) ?
                                       mac_ctrl_t'(32'h1) : mac_ctrl_t'(32'h0);

  mac_ctrl_t             mac_ctrl_q;
  logic [REG_DWIDTH-1:0] phy_ctrl_q;
  led_ctl_t              led_ctl_q;

  logic                  rd_mapped;      // Address hit this cycle
  logic [REG_DWIDTH-1:0] rd_mux;
  logic                  rd_hit_q;       // Stage 1
  logic [REG_DWIDTH-1:0] rd_data_q;
  logic                  resp_q;         // Stage 2, to bus
  logic [REG_DWIDTH-1:0] resp_data_q;

  // ------------------------------
  // Writable registers
  // ------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      mac_ctrl_q <= MAC_CTRL_RST;
      phy_ctrl_q <= '0;
      led_ctl_q  <= '0;
    end else if (reg_req_i.wr_req) begin
      case (reg_req_i.wr_addr)
        ADDR_MAC_CS:  mac_ctrl_q <= mac_ctrl_t'(reg_req_i.wr_data);
        ADDR_PHY_CS:  phy_ctrl_q <= reg_req_i.wr_data;
        ADDR_LED_CTL: led_ctl_q  <= led_ctl_t'(reg_req_i.wr_data[1:0]);
        default: ;  // Unmapped, dropped
      endcase
    end
  end

  assign mac_ctrl_o   = mac_ctrl_q;
  assign led_ctl_o    = led_ctl_q;
  // PHY held in reset by its own control bit
  assign phy_areset_o = phy_ctrl_q[0];

  // Compat, spare, live flags, protocol, port
  assign port_info_o = {COMPAT_NUM, 6'h0, activity_i, link_up_i, PROTOCOL, PORTNUM};

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb begin
    rd_mapped = 1'b1;
    rd_mux    = '0;
    case (reg_req_i.rd_addr)
      ADDR_PORT_INFO: rd_mux = port_info_o;
      ADDR_MAC_CS:    rd_mux = status_i.mac_status;
      ADDR_PHY_CS:    rd_mux = status_i.phy_status;
      ADDR_LED_CTL:   rd_mux = {30'h0, led_ctl_q};
      default:        rd_mapped = 1'b0;  // No response at all
    endcase
  end

  // Response strobe two edges after the request
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_hit_q <= 1'b0;
      resp_q   <= 1'b0;
    end else begin
      rd_hit_q <= reg_req_i.rd_req & rd_mapped;
      resp_q   <= rd_hit_q;
    end
  end

  // Data follows the strobe
  always_ff @(posedge bus_clk) begin
    rd_data_q   <= rd_mux;
    resp_data_q <= rd_data_q;
  end

  assign reg_resp_o = {resp_q, resp_data_q};

endmodule

// ==== mgt_activity_stage.sv ====
// MGT port activity indicator
// Stretches stream beat strobes into a visible LED pulse,
// with the identify setting taking over when enabled

`timescale 1ns/100ps

module mgt_activity_stage #(
  parameter int STRETCH_CYCLES = 16
) (
  input  logic                   bus_clk,
  input  logic                   bus_rst,
  input  logic                   tx_fire_i,   // Accepted TX beat
  input  logic                   rx_fire_i,   // Accepted RX beat
  input  logic                   link_up_i,
  input  mgt_port_pkg::led_ctl_t led_ctl_i,
  output logic                   activity_o
);

  localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

  logic [CNT_W-1:0] stretch_cnt;
  logic             stretch_busy;

  // Reload on any beat, run down otherwise
  always_ff @(posedge bus_clk) begin
    if (bus_rst || !link_up_i) begin
      stretch_cnt <= '0;  // No activity without a link
    end else if (tx_fire_i || rx_fire_i) begin
      stretch_cnt <= CNT_W'(STRETCH_CYCLES);
    end else if (stretch_cnt != '0) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  assign stretch_busy = link_up_i && (stretch_cnt != '0);

  // Identify wins over traffic
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      activity_o <= 1'b0;
    end else if (led_ctl_i.identify_en) begin
      activity_o <= led_ctl_i.identify_val;
    end else begin
      activity_o <= stretch_busy;
    end
  end

endmodule

// ==== mgt_port_top.sv ====
// MGT port control plane top level
// Status conditioning feeds the register block, which feeds the
// activity indicator; all in bus_clk

`timescale 1ns/100ps

module mgt_port_top #(
  parameter mgt_port_pkg::mgt_protocol_e PROTOCOL       = mgt_port_pkg::GBE10,
  parameter int                          REG_BASE       = 0,
  parameter logic [7:0]                  PORTNUM        = 8'd0,
  parameter int                          STRETCH_CYCLES = 16
) (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  // Link side
  input  mgt_port_pkg::link_flags_t link_flags_i,
  input  logic                      bist_locked_i,
  input  logic                      tx_fire_i,
  input  logic                      rx_fire_i,
  // Register port
  input  mgt_port_pkg::reg_req_t    reg_req_i,
  output mgt_port_pkg::reg_resp_t   reg_resp_o,
  // Misc
  output logic [31:0]               port_info_o,
  output logic                      link_up_o,
  output logic                      activity_o,
  output logic                      phy_areset_o
);

  import mgt_port_pkg::*;

  port_status_t port_status;
  mac_ctrl_t    mac_ctrl;
  led_ctl_t     led_ctl;

  // ------------------------------
  // Stage chain
  // ------------------------------
  mgt_status_stage mgt_status_stage_i (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .link_flags_i  (link_flags_i),
    .bist_locked_i (bist_locked_i),
    .checker_en_i  (mac_ctrl.checker_en),
    .mac_clear_i   (mac_ctrl.mac_clear),
    .status_o      (port_status),
    .link_up_o     (link_up_o)
  );

  mgt_reg_stage #(
    .PROTOCOL (PROTOCOL),
    .REG_BASE (REG_BASE),
    .PORTNUM  (PORTNUM)
  ) mgt_reg_stage_i (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .reg_req_i    (reg_req_i),
    .status_i     (port_status),
    .link_up_i    (link_up_o),
    .activity_i   (activity_o),
    .reg_resp_o   (reg_resp_o),
    .mac_ctrl_o   (mac_ctrl),
    .phy_areset_o (phy_areset_o),
    .led_ctl_o    (led_ctl),
    .port_info_o  (port_info_o)
  );

  mgt_activity_stage #(
    .STRETCH_CYCLES (STRETCH_CYCLES)
  ) mgt_activity_stage_i (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .tx_fire_i  (tx_fire_i),
    .rx_fire_i  (rx_fire_i),
    .link_up_i  (link_up_o),
    .led_ctl_i  (led_ctl),
    .activity_o (activity_o)
  );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source
// Free running bus clock and a reset held for a fixed cycle count

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50% duty
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;  // Release on an edge, like a real reset tree
  end

endmodule

// ==== mgt_port_tb.sv ====
// MGT port testbench
// Replays the golden operation list against the port top level,
// checking read data, response timing, status sync and LED behavior

`timescale 1ns/100ps

module mgt_port_tb;

  import mgt_port_pkg::*;

  localparam int TIMEOUT = 32;  // Cycles per wait loop
  localparam int STRETCH = 16;
  localparam logic [REG_AWIDTH-1:0] MAC_ADDR = REG_MAC_CTRL_STATUS;  // Base is 0
  localparam logic [REG_AWIDTH-1:0] PHY_ADDR = REG_PHY_CTRL_STATUS;

  logic         bus_clk;
  logic         bus_rst;
  link_flags_t  flags;
  logic         bist_locked;
  logic         tx_fire;
  logic         rx_fire;
  reg_req_t     req;
  reg_resp_t    resp;
  logic [31:0]  port_info;
  logic         link_up;
  logic         activity;
  logic         phy_areset;

  integer       seed;
  int           fd;
  int           n;
  int           pass_cnt;
  int           fail_cnt;
  logic         test_bad;
  logic         phy_ctl0;  // Shadow of PHY control bit 0
  string        line;
  string        name;
  string        op;
  logic [31:0]  arg;
  logic [31:0]  exp_val;

  tb_clock_gen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (10)
  ) tb_clock_gen_i (
    .clk_o (bus_clk),
    .rst_o (bus_rst)
  );

  mgt_port_top #(
    .PROTOCOL       (AURORA),
    .REG_BASE       (0),
    .PORTNUM        (8'd5),
    .STRETCH_CYCLES (STRETCH)
  ) mgt_port_top_i (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .link_flags_i  (flags),
    .bist_locked_i (bist_locked),
    .tx_fire_i     (tx_fire),
    .rx_fire_i     (rx_fire),
    .reg_req_i     (req),
    .reg_resp_o    (resp),
    .port_info_o   (port_info),
    .link_up_o     (link_up),
    .activity_o    (activity),
    .phy_areset_o  (phy_areset)
  );

  // ------------------------------
  // Checks and bus access
  // ------------------------------
  task automatic check_value(input string tname, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", tname, expected, actual);
      test_bad = 1'b1;
    end
  endtask

  // One read with the response due on the second edge after the request
  task automatic timed_read(input string tname, input logic [REG_AWIDTH-1:0] addr,
                            output logic [31:0] data, output int lat);
    req.rd_req  = 1'b1;
    req.rd_addr = addr;
    lat = 0;
    do begin
      @(negedge bus_clk);
      req.rd_req = 1'b0;  // Single cycle strobe
      lat++;
    end while (!resp.rd_resp && lat < TIMEOUT);
    data = resp.rd_data;
    if (!resp.rd_resp) begin
      $display("%s: read of %h got no response within %0d cycles", tname, addr, TIMEOUT);
      test_bad = 1'b1;
    end else begin
      check_value(tname, 32'd2, 32'(lat));
    end
  endtask

  // Repeats reads until the data matches or the budget runs out
  task automatic poll_read(input string tname, input logic [REG_AWIDTH-1:0] addr,
                           input logic [31:0] expected);
    logic [31:0] data;
    int          lat;
    int          spent;
    spent = 0;
    do begin
      timed_read(tname, addr, data, lat);
      spent += lat;
    end while (data !== expected && spent < TIMEOUT);
    check_value(tname, expected, data);
  endtask

  task automatic read_none(input string tname, input logic [REG_AWIDTH-1:0] addr);
    logic seen;
    seen        = 1'b0;
    req.rd_req  = 1'b1;
    req.rd_addr = addr;
    repeat (8) begin
      @(negedge bus_clk);
      req.rd_req = 1'b0;
      seen       = seen | resp.rd_resp;
    end
    check_value(tname, 32'd0, 32'(seen));
  endtask

  task automatic bus_write(input string tname, input logic [REG_AWIDTH-1:0] addr,
                           input logic [31:0] data);
    req.wr_req  = 1'b1;
    req.wr_addr = addr;
    req.wr_data = data;
    @(negedge bus_clk);
    req.wr_req = 1'b0;
    if (addr == PHY_ADDR) phy_ctl0 = data[0];
    // PHY reset follows PHY control bit 0
    check_value(tname, 32'(phy_ctl0), 32'(phy_areset));
  endtask

  // ------------------------------
  // Link, lock and activity
  // ------------------------------
  task automatic set_flags(input string tname, input logic [3:0] value, input logic up);
    int cyc;
    flags = link_flags_t'(value);
    cyc   = 0;
    do begin
      @(negedge bus_clk);
      cyc++;
    end while (link_up !== up && cyc < TIMEOUT);
    if (link_up !== up) begin
      $display("%s: link_up_o did not settle to %0d within %0d cycles", tname, up, TIMEOUT);
      test_bad = 1'b1;
    end
    check_value(tname, 32'(up), 32'(port_info[16]));  // Port info mirrors link_up
  endtask

  task automatic lock_test(input string tname, input logic locked, input logic expected);
    logic [31:0] first;
    logic [31:0] second;
    int          lat;
    int          spent;
    bist_locked = locked;
    spent       = 0;
    if (!locked) begin
      do begin
        timed_read(tname, MAC_ADDR, second, lat);
        spent += lat;
      end while (second[19:4] == 16'h0 && spent < TIMEOUT);
      check_value(tname, 32'(expected), 32'(second[19:4] != 16'h0));
    end else begin
      repeat (2) @(negedge bus_clk);
      timed_read(tname, MAC_ADDR, first, lat);
      repeat (20) @(negedge bus_clk);  // More than one 16 count field step
      timed_read(tname, MAC_ADDR, second, lat);
      check_value(tname, 32'(first[19:4]), 32'(second[19:4]));  // Frozen once locked
      check_value(tname, 32'(expected), 32'(second[3]));
    end
  endtask

  task automatic strobe(input logic use_rx);
    tx_fire = !use_rx;
    rx_fire = use_rx;
    @(negedge bus_clk);
    tx_fire = 1'b0;
    rx_fire = 1'b0;
  endtask

  // Pulse mode when strobes are expected to show, else level must hold
  task automatic fire_test(input string tname, input int count, input logic expected);
    int   since;
    int   gap;
    logic level;
    since = 0;
    for (int i = 0; i < count; i++) begin
      strobe(i[0]);  // Alternate TX and RX
      since = 1;
      if (i == 0 && expected) begin
        while (activity !== 1'b1 && since < TIMEOUT) begin
          @(negedge bus_clk);
          since++;
        end
        check_value(tname, 32'd2, 32'(since));
      end
      if (i != count - 1) begin
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge bus_clk);
      end
    end
    if (count != 0 && expected) begin
      while (activity !== 1'b0 && since < TIMEOUT) begin
        @(negedge bus_clk);
        since++;
      end
      if (since < STRETCH || since > STRETCH + 2) begin
        $display("%s: activity fell %0d cycles after the last strobe, outside %0d to %0d",
                 tname, since, STRETCH, STRETCH + 2);
        test_bad = 1'b1;
      end
    end else begin
      level = expected;
      repeat (STRETCH + 4) begin
        @(negedge bus_clk);
        if (activity !== expected && level === expected) level = activity;  // First slip
      end
      check_value(tname, 32'(expected), 32'(level));
    end
  endtask

  task automatic run_test(input string tname, input string kind, input logic [31:0] a,
                          input logic [31:0] e);
    test_bad = 1'b0;
    if (kind == "wr") begin
      bus_write(tname, a[REG_AWIDTH-1:0], e);
    end else if (kind == "rd") begin
      poll_read(tname, a[REG_AWIDTH-1:0], e);
    end else if (kind == "rd_none") begin
      read_none(tname, a[REG_AWIDTH-1:0]);
    end else if (kind == "flags") begin
      set_flags(tname, a[3:0], e[0]);
    end else if (kind == "lock") begin
      lock_test(tname, a[0], e[0]);
    end else if (kind == "fire") begin
      fire_test(tname, int'(a), e[0]);
    end else begin
      $display("%s: unknown operation %s in the golden file", tname, kind);
      test_bad = 1'b1;
    end
    if (test_bad) begin
      fail_cnt++;
      $display("FAIL %s", tname);
    end else begin
      pass_cnt++;
      $display("ok   %s", tname);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    flags       = '0;
    bist_locked = 1'b0;
    tx_fire     = 1'b0;
    rx_fire     = 1'b0;
    req         = '0;
    seed        = 80592;
    pass_cnt    = 0;
    fail_cnt    = 0;
    phy_ctl0    = 1'b0;
    n           = 0;
    do begin
      @(negedge bus_clk);
      n++;
    end while (bus_rst !== 1'b0 && n < TIMEOUT);
    fd = $fopen("mgt_port_golden.txt", "r");
    if (bus_rst !== 1'b0) begin
      $display("reset was never released");
      fail_cnt++;
    end else if (fd == 0) begin
      $display("cannot open mgt_port_golden.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        if (line.len() < 3 || line.getc(0) == "#") continue;  // Blank or comment
        if ($sscanf(line, "%s %s %h %h", name, op, arg, exp_val) != 4) continue;
        run_test(name, op, arg, exp_val);
      end
      $fclose(fd);
    end
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt != 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Whole run guard, far beyond the longest test list
  initial begin
    #200000;
    $display("simulation watchdog expired before the test list finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== mgt_port_golden.txt ====
# name op arg expected, arg and expected in hex
# wr: arg is address, expected is write data; fire: arg is strobe count; lock: arg is bist_locked
rst_mac     rd      4   01000000
rst_info    rd      0   02000305
led_wr      wr      c   2
led_rd      rd      c   2
led_clr     wr      c   0
unmapped    rd_none 30  0
areset_on   wr      8   1
areset_off  wr      8   0
link_up     flags   3   1
sync_mac    rd      4   01000003
sync_phy    rd      8   3
info_link   rd      0   02010305
crit_pulse  flags   b   1
crit_drop   flags   3   1
crit_held   rd      4   03000003
clear_set   wr      4   400
clear_rel   wr      4   0
crit_clr    rd      4   01000003
act_pulse   fire    5   1
ident_on    wr      c   3
ident_hold  fire    0   1
ident_off   wr      c   0
link_down   flags   0   0
act_nolink  fire    4   0
lat_en      wr      4   1
lat_count   lock    0   1
lat_hold    lock    1   1

// ==== list.f ====
mgt_port_pkg.sv
mgt_status_stage.sv
mgt_reg_stage.sv
mgt_activity_stage.sv
mgt_port_top.sv
tb_clock_gen.sv
mgt_port_tb.sv

// ==== Makefile ====
TOP := mgt_port_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "Some tests failed" sim.log

clean:
	rm -rf obj_dir sim.log
